// File: axil_kg_regfile.f
+incdir+include
rtl/kg_regfile_pkg.sv
rtl/axil_write_ctrl.sv
rtl/axil_read_ctrl.sv
rtl/kg_reg_bank.sv
rtl/axil_kg_regfile.sv
bench/axil_kg_regfile_properties.sv
bench/tb_axil_kg_regfile.sv

// File: bench/kg_regfile_tests.txt
# op addr data strb expected
# W: expected is the register after the write; R: data and strb unused, expected is the read word
R 0000 00000000 0 00000000
R 0008 00000000 0 00000000
R 0044 00000000 0 00000000
R 007c 00000000 0 00000000
W 0000 00000001 f 00000001
W 0004 a5a50010 f a5a50010
W 0008 00000001 f 00000001
W 000c deadbeef f deadbeef
R 0000 00000000 0 00000001
R 0004 00000000 0 a5a50010
R 0008 00000000 0 00000001
R 000c 00000000 0 deadbeef
W 0010 12345678 f 12345678
W 0010 aabbccdd 1 123456dd
W 0010 aabbccdd 4 12bb56dd
W 0010 99000000 8 99bb56dd
R 0010 00000000 0 99bb56dd
W 000c 0000ff00 2 deadffef
R 000c 00000000 0 deadffef
W 0014 cafef00d 3 0000f00d
R 0014 00000000 0 0000f00d
W 0040 ffffffff f ffffffff
R 00c0 00000000 0 ffffffff
W 0098 01020304 f 01020304
R 0018 00000000 0 01020304
W 00fc 55aa55aa f 55aa55aa
R 007c 00000000 0 55aa55aa
W 0084 00c0ffee 6 a5c0ff10
R 0004 00000000 0 a5c0ff10
W 0080 00000000 f 00000000
R 0000 00000000 0 00000000

// File: bench/tb_axil_kg_regfile.sv
// Runs bench/kg_regfile_tests.txt from the project root; one access at a time, all OKAY
`default_nettype none

module tb_axil_kg_regfile;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 64;
    localparam kg_regfile_pkg::axil_resp_t OKAY = 2'b00;

    logic                       clk;
    logic                       rst;
    kg_regfile_pkg::axil_addr_t awaddr, araddr;
    kg_regfile_pkg::axil_data_t wdata, rdata;
    kg_regfile_pkg::axil_strb_t wstrb;
    kg_regfile_pkg::axil_resp_t bresp, rresp;
    logic                       awvalid, awready, wvalid, wready, bvalid, bready;
    logic                       arvalid, arready, rvalid, rready;
    kg_regfile_pkg::axil_data_t kg_address_valid, kg_address, kg_data_valid, kg_data;

    // One entry per line of the test file
    logic [7:0]                 op_q [$];
    kg_regfile_pkg::axil_addr_t addr_q [$];
    kg_regfile_pkg::axil_data_t data_q [$];
    kg_regfile_pkg::axil_strb_t strb_q [$];
    kg_regfile_pkg::axil_data_t exp_q [$];
    logic [31:0]                lfsr_state;

    axil_kg_regfile i_axil_kg_regfile (.*);

    bind axil_kg_regfile axil_kg_regfile_properties i_axil_kg_regfile_properties (.*);

    always #5 clk = ~clk;

    // ------------------------------------------------------------------------
    // Error reporting and compares
    // ------------------------------------------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input kg_regfile_pkg::axil_data_t got,
                              input kg_regfile_pkg::axil_data_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input kg_regfile_pkg::axil_resp_t got,
                              input kg_regfile_pkg::axil_resp_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int cycles);
        int value;
        value = 0;
        for (int b = 0; b < 3; b++)
        begin
            lfsr_state = next_lfsr(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        // At least one cycle so the hold is always exercised
        cycles = value + 1;
    endtask

    task automatic load_tests();
        int                         fd;
        int                         count;
        string                      line;
        logic [7:0]                 op;
        kg_regfile_pkg::axil_addr_t addr;
        kg_regfile_pkg::axil_data_t data;
        kg_regfile_pkg::axil_strb_t strb;
        kg_regfile_pkg::axil_data_t expected;
        fd = $fopen("bench/kg_regfile_tests.txt", "r");
        if (fd == 0)
            abort_run("Cannot open the test file bench/kg_regfile_tests.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#")
                continue;
            count = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, expected);
            if (count == 5)
            begin
                op_q.push_back(op);
                addr_q.push_back(addr);
                data_q.push_back(data);
                strb_q.push_back(strb);
                exp_q.push_back(expected);
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------------------
    // Bus accesses
    // ------------------------------------------------------------------------

    task automatic run_write(input int i);
        int                         n;
        int                         hold;
        kg_regfile_pkg::reg_index_t idx;
        // Addresses wrap every 128 bytes, four bytes per register
        idx = kg_regfile_pkg::reg_index_t'((addr_q[i] % 128) / 4);
        @(posedge clk);
        awaddr  <= addr_q[i];
        wdata   <= data_q[i];
        wstrb   <= strb_q[i];
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        for (n = 0; n < WAIT_LIMIT; n++)
        begin
            @(posedge clk);
            if (awready && wready)
                break;
        end
        if (n == WAIT_LIMIT)
            abort_run("Write address and data were never accepted");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        for (n = 0; n < WAIT_LIMIT; n++)
        begin
            @(posedge clk);
            if (bvalid)
                break;
        end
        if (n == WAIT_LIMIT)
            abort_run("Write response never became valid");
        check_resp("bresp", bresp, OKAY);
        case (idx)
            0: check_data("kg_address_valid", kg_address_valid, exp_q[i]);
            1: check_data("kg_address", kg_address, exp_q[i]);
            2: check_data("kg_data_valid", kg_data_valid, exp_q[i]);
            3: check_data("kg_data", kg_data, exp_q[i]);
            default: ;
        endcase
        draw_delay(hold);
        // A following write is presented early and must wait for the response
        if (i + 1 < op_q.size() && op_q[i + 1] == "W")
        begin
            awaddr  <= addr_q[i + 1];
            wdata   <= data_q[i + 1];
            wstrb   <= strb_q[i + 1];
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end
        repeat (hold)
        begin
            @(posedge clk);
            check_flag("bvalid", bvalid, 1'b1);
            check_flag("awready", awready, 1'b0);
        end
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic run_read(input int i);
        int n;
        int hold;
        @(posedge clk);
        araddr  <= addr_q[i];
        arvalid <= 1'b1;
        for (n = 0; n < WAIT_LIMIT; n++)
        begin
            @(posedge clk);
            if (arready)
                break;
        end
        if (n == WAIT_LIMIT)
            abort_run("Read address was never accepted");
        arvalid <= 1'b0;
        for (n = 0; n < WAIT_LIMIT; n++)
        begin
            @(posedge clk);
            if (rvalid)
                break;
        end
        if (n == WAIT_LIMIT)
            abort_run("Read data never became valid");
        check_resp("rresp", rresp, OKAY);
        check_data("rdata", rdata, exp_q[i]);
        draw_delay(hold);
        // A following read is presented early and must wait until rvalid is taken
        if (i + 1 < op_q.size() && op_q[i + 1] == "R")
        begin
            araddr  <= addr_q[i + 1];
            arvalid <= 1'b1;
        end
        repeat (hold)
        begin
            @(posedge clk);
            check_flag("rvalid", rvalid, 1'b1);
            check_flag("arready", arready, 1'b0);
            check_data("rdata", rdata, exp_q[i]);
        end
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        lfsr_state = 32'hf5da_687a;
        load_tests();
        if (op_q.size() == 0)
            abort_run("The test file holds no operations");
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("bvalid", bvalid, 1'b0);
        check_flag("rvalid", rvalid, 1'b0);
        check_data("kg_address_valid", kg_address_valid, '0);
        check_data("kg_address", kg_address, '0);
        check_data("kg_data_valid", kg_data_valid, '0);
        check_data("kg_data", kg_data, '0);
        for (int i = 0; i < op_q.size(); i++)
        begin
            if (op_q[i] == "W")
                run_write(i);
            else if (op_q[i] == "R")
                run_read(i);
            else
                abort_run($sformatf("Unknown operation on test entry %0d", i));
        end
        if (i_axil_kg_regfile.i_axil_kg_regfile_properties.error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/axil_kg_regfile_properties.sv
// Handshake rules only, bound into the DUT; payload values are checked by the testbench
`default_nettype none

module axil_kg_regfile_properties
(
    input wire                             clk,
    input wire                             rst,
    input wire                             awready,
    input wire                             wready,
    input wire                             bvalid,
    input wire                             bready,
    input wire                             rvalid,
    input wire                             rready,
    input wire kg_regfile_pkg::axil_data_t rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    // Running count of failed assertions
    int error_count = 0;

    // ------------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------------

    assert property (@(posedge clk) disable iff (rst) awready == wready)
    else
    begin
        $error("awready and wready differ");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst) awready |=> !awready)
    else
    begin
        $error("awready stayed high for more than one cycle");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else
    begin
        $error("bvalid dropped before bready");
        error_count++;
    end

    // ------------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------------

    assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
    else
    begin
        $error("rvalid dropped before rready");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> $stable(rdata))
    else
    begin
        $error("rdata changed while waiting for rready");
        error_count++;
    end

endmodule

`default_nettype wire

// File: rtl/axil_kg_regfile.sv
// AXI4-Lite slave, one outstanding access per channel, awaddr/wdata must arrive together
`default_nettype none

module axil_kg_regfile
(
    input  wire                         clk,
    input  wire                         rst,

    // Write address and data
    input  wire kg_regfile_pkg::axil_addr_t awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire kg_regfile_pkg::axil_data_t wdata,
    input  wire kg_regfile_pkg::axil_strb_t wstrb,
    input  wire                         wvalid,
    output logic                        wready,

    // Write response
    output kg_regfile_pkg::axil_resp_t  bresp,
    output logic                        bvalid,
    input  wire                         bready,

    // Read address and data
    input  wire kg_regfile_pkg::axil_addr_t araddr,
    input  wire                         arvalid,
    output logic                        arready,
    output kg_regfile_pkg::axil_data_t  rdata,
    output kg_regfile_pkg::axil_resp_t  rresp,
    output logic                        rvalid,
    input  wire                         rready,

    // Key generator, registers 0 to 3
    output kg_regfile_pkg::axil_data_t  kg_address_valid,
    output kg_regfile_pkg::axil_data_t  kg_address,
    output kg_regfile_pkg::axil_data_t  kg_data_valid,
    output kg_regfile_pkg::axil_data_t  kg_data
);

    logic                        wr_en;
    kg_regfile_pkg::reg_index_t  wr_index;
    kg_regfile_pkg::reg_index_t  rd_index;
    kg_regfile_pkg::axil_data_t  rd_data;

    axil_write_ctrl i_axil_write_ctrl
    (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .wvalid   (wvalid),
        .bready   (bready),
        .awready  (awready),
        .wready   (wready),
        .bvalid   (bvalid),
        .bresp    (bresp),
        .wr_en    (wr_en),
        .wr_index (wr_index)
    );

    axil_read_ctrl i_axil_read_ctrl
    (
        .clk      (clk),
        .rst      (rst),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .rready   (rready),
        .rd_data  (rd_data),
        .arready  (arready),
        .rvalid   (rvalid),
        .rresp    (rresp),
        .rdata    (rdata),
        .rd_index (rd_index)
    );

    // wdata and wstrb are still held by the master while wr_en is high
    kg_reg_bank i_kg_reg_bank
    (
        .clk              (clk),
        .rst              (rst),
        .wr_en            (wr_en),
        .wr_index         (wr_index),
        .wr_data          (wdata),
        .wr_strb          (wstrb),
        .rd_index         (rd_index),
        .rd_data          (rd_data),
        .kg_address_valid (kg_address_valid),
        .kg_address       (kg_address),
        .kg_data_valid    (kg_data_valid),
        .kg_data          (kg_data)
    );

endmodule

`default_nettype wire

// File: rtl/kg_reg_bank.sv
// 32 x 32-bit registers cleared by reset; registers 0 to 3 feed the key generator
`default_nettype none

`include "kg_regfile_macros.svh"

module kg_reg_bank
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             wr_en,
    input  wire kg_regfile_pkg::reg_index_t wr_index,
    input  wire kg_regfile_pkg::axil_data_t wr_data,
    input  wire kg_regfile_pkg::axil_strb_t wr_strb,
    input  wire kg_regfile_pkg::reg_index_t rd_index,
    output kg_regfile_pkg::axil_data_t      rd_data,
    output kg_regfile_pkg::axil_data_t      kg_address_valid,
    output kg_regfile_pkg::axil_data_t      kg_address,
    output kg_regfile_pkg::axil_data_t      kg_data_valid,
    output kg_regfile_pkg::axil_data_t      kg_data
);

    kg_regfile_pkg::axil_data_t regs [`KG_REG_COUNT];

    // ------------------------------------------------------------------------
    // Byte-lane write
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `KG_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            for (int b = 0; b < `KG_STRB_WIDTH; b++)
            begin
                // Lanes with a low strobe keep their old byte
                if (wr_strb[b])
                begin
                    regs[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read mux and key generator taps
    // ------------------------------------------------------------------------

    assign rd_data = regs[rd_index];

    assign kg_address_valid = regs[0];
    assign kg_address       = regs[1];
    assign kg_data_valid    = regs[2];
    assign kg_data          = regs[3];

endmodule

`default_nettype wire

// File: rtl/axil_read_ctrl.sv
// One read in flight; a new address is taken only after rvalid has been accepted
`default_nettype none

`include "kg_regfile_macros.svh"

module axil_read_ctrl
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire kg_regfile_pkg::axil_addr_t araddr,
    input  wire                             arvalid,
    input  wire                             rready,
    input  wire kg_regfile_pkg::axil_data_t rd_data,
    output logic                            arready,
    output logic                            rvalid,
    output kg_regfile_pkg::axil_resp_t      rresp,
    output kg_regfile_pkg::axil_data_t      rdata,
    output kg_regfile_pkg::reg_index_t      rd_index
);

    kg_regfile_pkg::rd_state_t state;
    logic                      start;

    assign start   = (state == kg_regfile_pkg::RD_IDLE) && arvalid;
    assign arready = (state == kg_regfile_pkg::RD_ACCEPT);
    assign rvalid  = (state == kg_regfile_pkg::RD_DATA);

    // ------------------------------------------------------------------------
    // Read FSM with data capture
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= kg_regfile_pkg::RD_IDLE;
            rdata <= '0;
            rresp <= '0;
        end
        else
        begin
            case (state)
                kg_regfile_pkg::RD_IDLE:
                begin
                    if (start)
                    begin
                        state <= kg_regfile_pkg::RD_ACCEPT;
                    end
                end
                kg_regfile_pkg::RD_ACCEPT:
                begin
                    // Bank word for the latched index
                    rdata <= rd_data;
                    rresp <= kg_regfile_pkg::RESP_OKAY;
                    state <= kg_regfile_pkg::RD_DATA;
                end
                kg_regfile_pkg::RD_DATA:
                begin
                    if (rready)
                    begin
                        state <= kg_regfile_pkg::RD_IDLE;
                    end
                end
                default:
                begin
                    state <= kg_regfile_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // Index latch
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rd_index <= araddr[`KG_ADDR_LSB +: `KG_INDEX_WIDTH];
        end
    end

endmodule

`default_nettype wire

// File: rtl/axil_write_ctrl.sv
// Waits for awvalid and wvalid together; no new write until the response is taken
`default_nettype none

`include "kg_regfile_macros.svh"

module axil_write_ctrl
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire kg_regfile_pkg::axil_addr_t awaddr,
    input  wire                             awvalid,
    input  wire                             wvalid,
    input  wire                             bready,
    output logic                            awready,
    output logic                            wready,
    output logic                            bvalid,
    output kg_regfile_pkg::axil_resp_t      bresp,
    output logic                            wr_en,
    output kg_regfile_pkg::reg_index_t      wr_index
);

    kg_regfile_pkg::wr_state_t state;
    logic                      start;
    logic                      accept;

    // Address and data both presented while idle
    assign start  = (state == kg_regfile_pkg::WR_IDLE) && awvalid && wvalid;
    assign accept = (state == kg_regfile_pkg::WR_ACCEPT);

    // Both readies share the single accept cycle
    assign awready = accept;
    assign wready  = accept;
    assign wr_en   = accept;
    assign bvalid  = (state == kg_regfile_pkg::WR_RESP);

    // ------------------------------------------------------------------------
    // Write FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= kg_regfile_pkg::WR_IDLE;
            bresp <= '0;
        end
        else
        begin
            case (state)
                kg_regfile_pkg::WR_IDLE:
                begin
                    if (start)
                    begin
                        state <= kg_regfile_pkg::WR_ACCEPT;
                    end
                end
                kg_regfile_pkg::WR_ACCEPT:
                begin
                    // Bank is written at this same edge
                    state <= kg_regfile_pkg::WR_RESP;
                    bresp <= kg_regfile_pkg::RESP_OKAY;
                end
                kg_regfile_pkg::WR_RESP:
                begin
                    if (bready)
                    begin
                        state <= kg_regfile_pkg::WR_IDLE;
                    end
                end
                default:
                begin
                    state <= kg_regfile_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Address latch, only the word index is kept
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            wr_index <= awaddr[`KG_ADDR_LSB +: `KG_INDEX_WIDTH];
        end
    end

endmodule

`default_nettype wire

// File: rtl/kg_regfile_pkg.sv
// Types sized from the macros header; only OKAY responses are ever produced
`default_nettype none

package kg_regfile_pkg;

    `include "kg_regfile_macros.svh"

    typedef logic [`KG_ADDR_WIDTH-1:0]  axil_addr_t;
    typedef logic [`KG_DATA_WIDTH-1:0]  axil_data_t;
    typedef logic [`KG_STRB_WIDTH-1:0]  axil_strb_t;
    typedef logic [1:0]                 axil_resp_t;
    typedef logic [`KG_INDEX_WIDTH-1:0] reg_index_t;

    // AXI response codes
    localparam axil_resp_t RESP_OKAY = 2'b00;

    // Write channel FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACCEPT,
        WR_RESP
    } wr_state_t;

    // Read channel FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACCEPT,
        RD_DATA
    } rd_state_t;

endpackage

`default_nettype wire

// File: include/kg_regfile_macros.svh
// Fixed 32-bit bus; the index position assumes word-aligned 32-bit registers only
`ifndef KG_REGFILE_MACROS_SVH
`define KG_REGFILE_MACROS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------

`define KG_DATA_WIDTH 32
`define KG_ADDR_WIDTH 16

// One strobe bit per byte lane
`define KG_STRB_WIDTH 4

// ---------------------------------------------------------------------------
// Register space
// ---------------------------------------------------------------------------

`define KG_REG_COUNT 32
`define KG_INDEX_WIDTH 5

// Byte offset bits below the index are ignored
`define KG_ADDR_LSB 2

`endif
